/* include/regfile_params.svh */
`ifndef REGFILE_PARAMS_SVH
`define REGFILE_PARAMS_SVH

// Register word and address widths
`define NB_DATA     32
`define NB_ADDR     5

// Bank organization
`define BANK_DEPTH  32
`define SLICE_DEPTH 8   // Registers held by one slice

// Slices needed to cover the bank
`define N_SLICES    (`BANK_DEPTH / `SLICE_DEPTH)

`endif

/* source/regfile_pkg.sv */
`default_nettype none

package regfile_pkg;

    `include "regfile_params.svh"

    // One architectural register
    typedef logic [`NB_DATA-1:0] reg_data_t;

    // Register number as seen by the pipeline
    typedef logic [`NB_ADDR-1:0] reg_addr_t;

    // Upper address bits pick the slice
    typedef logic [$clog2(`N_SLICES)-1:0] slice_idx_t;

    // Lower address bits pick the register in a slice
    typedef logic [$clog2(`SLICE_DEPTH)-1:0] local_idx_t;

endpackage

`default_nettype wire

/* source/debug_pkg.sv */
`default_nettype none

package debug_pkg;

    // Progress of one APB transfer
    typedef enum logic [1:0] {
        IDLE,         // Waiting for a setup cycle
        ACCESS_WAIT,  // Access phase, pipeline not yet seen halted
        ACCESS_DONE   // o_pready high for one cycle
    } apb_phase_t;

    // APB byte address, one word per register
    typedef logic [7:0] dbg_addr_t;

    localparam int DBG_REG_MSB = 6;
    localparam int DBG_REG_LSB = 2;

    // Word aligned and inside the 32 register window
    function automatic logic dbg_addr_ok(input dbg_addr_t addr);
        return (addr[1:0] == 2'b00) && !addr[7];
    endfunction

endpackage

`default_nettype wire

/* source/regfile_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regfile_params.svh"

// Write port shared by all slices
interface bank_write_if
    import regfile_pkg::*;
();

    logic                  we;
    logic [`N_SLICES-1:0]  slice_sel;  // One-hot
    local_idx_t            local_idx;
    reg_data_t             data;

    modport decoder (
        output we,
        output slice_sel,
        output local_idx,
        output data
    );

    modport slice (
        input  we,
        input  slice_sel,
        input  local_idx,
        input  data
    );

    // Forwarding only needs the write strobe and word
    modport mux (
        input  we,
        input  data
    );

endinterface

// One per slice, three local reads
interface slice_read_if
    import regfile_pkg::*;
();

    local_idx_t local_a;
    local_idx_t local_b;
    local_idx_t local_dbg;
    reg_data_t  rdata_a;
    reg_data_t  rdata_b;
    reg_data_t  rdata_dbg;

    modport mux (
        output local_a,
        output local_b,
        output local_dbg,
        input  rdata_a,
        input  rdata_b,
        input  rdata_dbg
    );

    modport slice (
        input  local_a,
        input  local_b,
        input  local_dbg,
        output rdata_a,
        output rdata_b,
        output rdata_dbg
    );

endinterface

`default_nettype wire

/* source/write_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module write_decoder
    import regfile_pkg::*;
(
    input  wire             i_clock,
    input  wire             i_reset,

    // Pipeline write-back
    input  wire             i_reg_write,
    input  wire             i_enable,
    input  wire reg_addr_t  i_write_reg,
    input  wire reg_data_t  i_write_data,

    // Debug write request
    input  wire             i_dbg_we,
    input  wire reg_addr_t  i_dbg_reg,
    input  wire reg_data_t  i_dbg_data,

    bank_write_if.decoder   wr
);

    reg_addr_t  addr_sel;
    slice_idx_t slice_num;
    local_idx_t local_num;

    // Pipeline owns the port while running, debug while halted
    always_comb begin
        if (i_enable) begin
            wr.we    = i_reg_write;
            addr_sel = i_write_reg;
            wr.data  = i_write_data;
        end else begin
            wr.we    = i_dbg_we;
            addr_sel = i_dbg_reg;
            wr.data  = i_dbg_data;
        end
    end

    assign {slice_num, local_num} = addr_sel;
    assign wr.local_idx = local_num;

    always_comb begin
        wr.slice_sel            = '0;
        wr.slice_sel[slice_num] = 1'b1;
    end

    // Debug port must only write once the core is halted
    a_dbg_write_halted : assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_dbg_we |-> !i_enable
    ) else $error("Debug write issued while pipeline enabled");

endmodule

`default_nettype wire

/* source/register_slice.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regfile_params.svh"

module register_slice
    import regfile_pkg::*;
#(
    parameter int SLICE_ID = 0   // Position of this slice in the bank
)
(
    input  wire           i_clock,
    input  wire           i_reset,
    bank_write_if.slice   wr,
    slice_read_if.slice   rd
);

    reg_data_t regs [`SLICE_DEPTH];
    logic      slice_we;

    assign slice_we = wr.we && wr.slice_sel[SLICE_ID];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `SLICE_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (slice_we) begin
            regs[wr.local_idx] <= wr.data;
        end
    end

    // Asynchronous reads, forwarding is done in the mux
    assign rd.rdata_a   = regs[rd.local_a];
    assign rd.rdata_b   = regs[rd.local_b];
    assign rd.rdata_dbg = regs[rd.local_dbg];

    // Two slices written in one cycle would corrupt the bank
    a_sel_onehot : assert property (
        @(posedge i_clock) disable iff (i_reset)
        wr.we |-> $onehot0(wr.slice_sel)
    ) else $error("Slice select not one-hot during write");

endmodule

`default_nettype wire

/* source/read_port_mux.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regfile_params.svh"

module read_port_mux
    import regfile_pkg::*;
(
    input  wire             i_clock,
    input  wire             i_reset,
    input  wire             i_enable,

    input  wire             i_reg_write,
    input  wire reg_addr_t  i_read_reg_a,
    input  wire reg_addr_t  i_read_reg_b,
    input  wire reg_addr_t  i_write_reg,
    bank_write_if.mux       wr,
    slice_read_if.mux       rd [`N_SLICES],

    input  wire reg_addr_t  i_dbg_reg,
    output reg_data_t       o_dbg_data,

    output reg_data_t       o_data_a,
    output reg_data_t       o_data_b
);

    slice_idx_t slice_a;
    slice_idx_t slice_b;
    slice_idx_t slice_dbg;
    local_idx_t local_a;
    local_idx_t local_b;
    local_idx_t local_dbg;

    reg_data_t  rdata_a   [`N_SLICES];
    reg_data_t  rdata_b   [`N_SLICES];
    reg_data_t  rdata_dbg [`N_SLICES];

    logic       pipe_write;
    logic       hit_a;
    logic       hit_b;

    assign {slice_a, local_a}     = i_read_reg_a;
    assign {slice_b, local_b}     = i_read_reg_b;
    assign {slice_dbg, local_dbg} = i_dbg_reg;

    // Every slice sees the same local index, the slice number picks the result
    for (genvar g = 0; g < `N_SLICES; g++) begin : g_slice_link
        assign rd[g].local_a   = local_a;
        assign rd[g].local_b   = local_b;
        assign rd[g].local_dbg = local_dbg;
        assign rdata_a[g]      = rd[g].rdata_a;
        assign rdata_b[g]      = rd[g].rdata_b;
        assign rdata_dbg[g]    = rd[g].rdata_dbg;
    end

    assign o_dbg_data = rdata_dbg[slice_dbg];

    // Only a write-back from the pipeline is forwarded
    assign pipe_write = wr.we && i_reg_write;
    assign hit_a      = pipe_write && (i_write_reg == i_read_reg_a);
    assign hit_b      = pipe_write && (i_write_reg == i_read_reg_b);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_data_a <= '0;
            o_data_b <= '0;
        end else if (i_enable) begin  // Halted core keeps its operands
            // Port a first, port b can still match the same write
            if (hit_a) begin
                o_data_a <= wr.data;
                o_data_b <= hit_b ? wr.data : rdata_b[slice_b];
            end else if (hit_b) begin
                o_data_a <= rdata_a[slice_a];
                o_data_b <= wr.data;
            end else begin
                o_data_a <= rdata_a[slice_a];
                o_data_b <= rdata_b[slice_b];
            end
        end
    end

endmodule

`default_nettype wire

/* source/apb_debug_port.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_debug_port
    import regfile_pkg::*;
    import debug_pkg::*;
(
    input  wire             i_clock,
    input  wire             i_reset,
    input  wire             i_enable,

    // APB slave
    input  wire             i_psel,
    input  wire             i_penable,
    input  wire             i_pwrite,
    input  wire dbg_addr_t  i_paddr,
    input  wire reg_data_t  i_pwdata,
    output reg_data_t       o_prdata,
    output logic            o_pready,
    output logic            o_pslverr,

    // Register bank side
    input  wire reg_data_t  i_dbg_data,
    output logic            o_dbg_we,
    output reg_addr_t       o_dbg_reg,
    output reg_data_t       o_dbg_data
);

    apb_phase_t phase;
    logic       addr_ok;

    assign addr_ok    = dbg_addr_ok(i_paddr);
    assign o_dbg_reg  = i_paddr[DBG_REG_MSB:DBG_REG_LSB];
    assign o_dbg_data = i_pwdata;

    // Write commits at the edge that ends the ready cycle
    assign o_dbg_we = (phase == ACCESS_DONE) && i_pwrite && addr_ok;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase     <= IDLE;
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
        end else begin
            case (phase)
                IDLE: begin
                    if (i_psel && !i_penable) phase <= ACCESS_WAIT;  // Setup seen
                end
                ACCESS_WAIT: begin
                    if (!i_psel) begin
                        phase <= IDLE;  // Host dropped the transfer
                    end else if (i_penable && !i_enable) begin
                        phase     <= ACCESS_DONE;
                        o_pready  <= 1'b1;
                        o_pslverr <= !addr_ok;
                    end
                end
                default: begin
                    phase     <= IDLE;
                    o_pready  <= 1'b0;
                    o_pslverr <= 1'b0;
                end
            endcase
        end
    end

    // Read word captured with the ready, zero on error or write
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_prdata <= '0;
        end else if (phase == ACCESS_WAIT && i_psel && i_penable && !i_enable) begin
            o_prdata <= (!i_pwrite && addr_ok) ? i_dbg_data : '0;
        end
    end

    a_penable_needs_psel : assert property (
        @(posedge i_clock) disable iff (i_reset)
        $rose(i_penable) |-> i_psel
    ) else $error("APB penable rose without psel");

endmodule

`default_nettype wire

/* source/register_bank_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regfile_params.svh"

module register_bank_top (
    input  wire                 i_clock,
    input  wire                 i_reset,

    // Pipeline side
    input  wire                 i_reg_write,  // From write-back
    input  wire [`NB_ADDR-1:0]  i_read_reg_a,
    input  wire [`NB_ADDR-1:0]  i_read_reg_b,
    input  wire [`NB_ADDR-1:0]  i_write_reg,
    input  wire [`NB_DATA-1:0]  i_write_data,
    input  wire                 i_enable,     // Low while halted for debug
    output logic [`NB_DATA-1:0] o_data_a,
    output logic [`NB_DATA-1:0] o_data_b,

    // APB debug access
    input  wire                 i_psel,
    input  wire                 i_penable,
    input  wire                 i_pwrite,
    input  wire [7:0]           i_paddr,
    input  wire [`NB_DATA-1:0]  i_pwdata,
    output logic [`NB_DATA-1:0] o_prdata,
    output logic                o_pready,
    output logic                o_pslverr
);

    logic                dbg_we;
    logic [`NB_ADDR-1:0] dbg_reg;
    logic [`NB_DATA-1:0] dbg_wdata;
    logic [`NB_DATA-1:0] dbg_rdata;

    bank_write_if wr_bus ();
    slice_read_if rd_bus [`N_SLICES] ();

    write_decoder u_write_decoder (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_reg_write  (i_reg_write),
        .i_enable     (i_enable),
        .i_write_reg  (i_write_reg),
        .i_write_data (i_write_data),
        .i_dbg_we     (dbg_we),
        .i_dbg_reg    (dbg_reg),
        .i_dbg_data   (dbg_wdata),
        .wr           (wr_bus)
    );

    for (genvar g = 0; g < `N_SLICES; g++) begin : g_slice
        register_slice #(.SLICE_ID(g)) u_slice (
            .i_clock (i_clock),
            .i_reset (i_reset),
            .wr      (wr_bus),
            .rd      (rd_bus[g])
        );
    end

    read_port_mux u_read_port_mux (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_enable     (i_enable),
        .i_reg_write  (i_reg_write),
        .i_read_reg_a (i_read_reg_a),
        .i_read_reg_b (i_read_reg_b),
        .i_write_reg  (i_write_reg),
        .wr           (wr_bus),
        .rd           (rd_bus),
        .i_dbg_reg    (dbg_reg),
        .o_dbg_data   (dbg_rdata),
        .o_data_a     (o_data_a),
        .o_data_b     (o_data_b)
    );

    apb_debug_port u_apb_debug_port (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_enable   (i_enable),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .i_dbg_data (dbg_rdata),
        .o_dbg_we   (dbg_we),
        .o_dbg_reg  (dbg_reg),
        .o_dbg_data (dbg_wdata)
    );

endmodule

`default_nettype wire

/* verification/clock_reset_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_reset_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
)
(
    output logic o_clock,
    output logic o_reset
);

    initial begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2) o_clock = ~o_clock;
    end

    // Released just after an edge, like every other input
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        #1 o_reset = 1'b0;
    end

endmodule

`default_nettype wire

/* verification/register_bank_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regfile_params.svh"

module register_bank_tb
    import debug_pkg::*;
();

    localparam int DRIVE_DELAY  = 1;
    localparam int N_RANDOM     = 150;
    localparam int APB_MAX_WAIT = 16;
    // Rough length of tests 1 to 6 in cycles
    localparam int TEST_CYCLES  = 60 + (2 * N_RANDOM + 10) + 30 + 50 + 320 + 70;
    localparam int TIMEOUT      = 2 * TEST_CYCLES;

    logic                clock;
    logic                reset;
    logic                reg_write;
    logic [`NB_ADDR-1:0] read_reg_a;
    logic [`NB_ADDR-1:0] read_reg_b;
    logic [`NB_ADDR-1:0] write_reg;
    logic [`NB_DATA-1:0] write_data;
    logic                enable;
    logic                psel;
    logic                penable;
    logic                pwrite;
    dbg_addr_t           paddr;
    logic [`NB_DATA-1:0] pwdata;
    logic [`NB_DATA-1:0] data_a;
    logic [`NB_DATA-1:0] data_b;
    logic [`NB_DATA-1:0] prdata;
    logic                pready;
    logic                pslverr;

    // Reference model state
    logic [`NB_DATA-1:0] model [`BANK_DEPTH];
    logic [`NB_DATA-1:0] exp_data_a;
    logic [`NB_DATA-1:0] exp_data_b;
    logic [`NB_DATA-1:0] exp_prdata;
    logic                exp_pready;
    logic                exp_pslverr;
    logic                exp_rd_check;  // Valid debug read in its ready cycle
    logic                in_access;

    int     error_count          = 0;
    int     test_count           = 0;
    int     failed_tests         = 0;
    int     test_errors_at_start = 0;
    int     cycle_count          = 0;
    integer seed                 = 66771;

    clock_reset_gen u_clock_reset_gen (
        .o_clock (clock),
        .o_reset (reset)
    );

    register_bank_top UUT (
        .i_clock      (clock),
        .i_reset      (reset),
        .i_reg_write  (reg_write),
        .i_read_reg_a (read_reg_a),
        .i_read_reg_b (read_reg_b),
        .i_write_reg  (write_reg),
        .i_write_data (write_data),
        .i_enable     (enable),
        .o_data_a     (data_a),
        .o_data_b     (data_b),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .o_prdata     (prdata),
        .o_pready     (pready),
        .o_pslverr    (pslverr)
    );

    // Word aligned and below 0x80
    function automatic logic debug_addr_legal(input dbg_addr_t addr);
        return (addr[1:0] == 2'b00) && (addr[7] == 1'b0);
    endfunction

    function automatic logic [`NB_ADDR-1:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[`NB_ADDR-1:0];
    endfunction

    function automatic logic [`NB_DATA-1:0] rand_word();
        return $random(seed);
    endfunction

    function void report_word(input string what, input logic [`NB_DATA-1:0] got, want);
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
        error_count++;
    endfunction

    function void report_bit(input string what, input logic got, want);
        $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, want);
        error_count++;
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            exp_data_a   <= '0;
            exp_data_b   <= '0;
            exp_prdata   <= '0;
            exp_pready   <= 1'b0;
            exp_pslverr  <= 1'b0;
            exp_rd_check <= 1'b0;
            in_access    <= 1'b0;
            for (int i = 0; i < `BANK_DEPTH; i++) begin
                model[i] <= '0;
            end
        end else begin
            if (enable) begin  // Operands hold while halted
                exp_data_a <= (reg_write && write_reg == read_reg_a) ? write_data
                                                                     : model[read_reg_a];
                exp_data_b <= (reg_write && write_reg == read_reg_b) ? write_data
                                                                     : model[read_reg_b];
                if (reg_write) model[write_reg] <= write_data;
            end
            if (exp_pready) begin
                exp_pready   <= 1'b0;
                exp_pslverr  <= 1'b0;
                exp_rd_check <= 1'b0;
                if (pwrite && debug_addr_legal(paddr)) model[paddr[6:2]] <= pwdata;
            end else if (in_access && psel && penable && !enable) begin
                exp_pready   <= 1'b1;
                exp_pslverr  <= !debug_addr_legal(paddr);
                exp_rd_check <= !pwrite && debug_addr_legal(paddr);
                exp_prdata   <= model[paddr[6:2]];
                in_access    <= 1'b0;
            end else if (psel && !penable) begin
                in_access <= 1'b1;  // Setup cycle seen
            end else if (!psel) begin
                in_access <= 1'b0;
            end
        end
    end

    a_data_a : assert property (@(posedge clock) disable iff (reset) data_a == exp_data_a)
        else report_word("o_data_a", $sampled(data_a), $sampled(exp_data_a));
    a_data_b : assert property (@(posedge clock) disable iff (reset) data_b == exp_data_b)
        else report_word("o_data_b", $sampled(data_b), $sampled(exp_data_b));
    a_pready : assert property (@(posedge clock) disable iff (reset) pready == exp_pready)
        else report_bit("o_pready", $sampled(pready), $sampled(exp_pready));
    a_pslverr : assert property (@(posedge clock) disable iff (reset) pslverr == exp_pslverr)
        else report_bit("o_pslverr", $sampled(pslverr), $sampled(exp_pslverr));
    a_prdata : assert property (
        @(posedge clock) disable iff (reset)
        exp_rd_check |-> prdata == exp_prdata
    ) else report_word("o_prdata", $sampled(prdata), $sampled(exp_prdata));

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Run timed out after %0d cycles before all tests finished", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic pipeline_cycle(input logic wr, input logic [`NB_ADDR-1:0] wreg,
                                  input logic [`NB_DATA-1:0] wdata,
                                  input logic [`NB_ADDR-1:0] ra, rb);
        reg_write  = wr;
        write_reg  = wreg;
        write_data = wdata;
        read_reg_a = ra;
        read_reg_b = rb;
        next_cycle();
    endtask

    // Core is halted after run_cycles access cycles
    task automatic apb_transfer(input logic write, input dbg_addr_t addr,
                                input logic [`NB_DATA-1:0] wdata, input int run_cycles,
                                output int cycles);
        int waited;
        waited  = 0;
        psel    = 1'b1;  // Setup
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;
        while (!pready && waited < APB_MAX_WAIT) begin
            if (waited == run_cycles) enable = 1'b0;
            next_cycle();
            waited++;
        end
        if (!pready) begin
            $display("APB transfer to address %h never raised o_pready", addr);
            error_count++;
        end
        cycles = waited + 2;  // Setup and ready cycles included
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic halted_transfer(input logic write, input dbg_addr_t addr,
                                   input logic [`NB_DATA-1:0] wdata);
        int cycles;
        apb_transfer(write, addr, wdata, 0, cycles);
        assert (cycles == 3) else begin
            $display("ERROR at %0t ns: halted APB transfer took %0d cycles, expected 3",
                     $time, cycles);
            error_count++;
        end
    endtask

    // Stalled access cycles plus one halted access, setup and ready cycle
    task automatic check_stalled_length(input int cycles, input int run_cycles);
        assert (cycles == run_cycles + 3) else begin
            $display("ERROR at %0t ns: stalled APB transfer took %0d cycles, expected %0d",
                     $time, cycles, run_cycles + 3);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        int errors;
        reg_write = 1'b0;
        repeat (2) next_cycle();  // Last results reach the assertions
        errors = error_count - test_errors_at_start;
        test_count++;
        if (errors != 0) failed_tests++;
        $display("Test %0d %s: %s (%0d errors)", test_count, name,
                 (errors == 0) ? "passed" : "failed", errors);
        test_errors_at_start = error_count;
    endtask

    initial begin
        logic [`NB_ADDR-1:0] r;
        logic [`NB_ADDR-1:0] other;
        int                  cycles;
        reg_write  = 1'b0;
        read_reg_a = '0;
        read_reg_b = '0;
        write_reg  = '0;
        write_data = '0;
        enable     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        @(negedge reset);
        enable = 1'b1;

        for (int i = 0; i < `BANK_DEPTH; i++) pipeline_cycle(1'b0, '0, '0, i[4:0], ~i[4:0]);
        enable = 1'b0;
        next_cycle();
        for (int i = 0; i < 4; i++) halted_transfer(1'b0, {1'b0, rand_reg(), 2'b00}, '0);
        enable = 1'b1;
        finish_test("reset state");

        for (int i = 0; i < N_RANDOM; i++) begin
            pipeline_cycle(1'b1, rand_reg(), rand_word(), rand_reg(), rand_reg());
        end
        for (int i = 0; i < N_RANDOM; i++) pipeline_cycle(1'b0, '0, '0, rand_reg(), rand_reg());
        finish_test("random writes and reads");

        for (int i = 0; i < 8; i++) begin
            r     = rand_reg();
            other = r ^ 5'd1;
            pipeline_cycle(1'b1, r, rand_word(), r, other);
            pipeline_cycle(1'b1, r, rand_word(), other, r);
            pipeline_cycle(1'b1, r, rand_word(), r, r);
        end
        finish_test("write-back forwarding");

        pipeline_cycle(1'b0, '0, '0, rand_reg(), rand_reg());
        enable = 1'b0;
        for (int i = 0; i < 20; i++) pipeline_cycle(1'b1, i[4:0], rand_word(), rand_reg(), r);
        enable = 1'b1;
        for (int i = 0; i < 20; i++) pipeline_cycle(1'b0, '0, '0, i[4:0], rand_reg());
        finish_test("halted pipeline");

        enable = 1'b0;
        next_cycle();
        for (int i = 0; i < 16; i++) begin
            r = rand_reg();
            halted_transfer(1'b1, {1'b0, r, 2'b00}, rand_word());
            halted_transfer(1'b0, {1'b0, r, 2'b00}, '0);
            halted_transfer(1'b0, {1'b0, rand_reg(), 2'b00}, '0);
        end
        for (int i = 0; i < 4; i++) begin
            r = rand_reg();
            halted_transfer(1'b1, {1'b0, r, 2'b01}, rand_word());
            halted_transfer(1'b1, {1'b0, r, 2'b10}, rand_word());
            halted_transfer(1'b1, {1'b1, r, 2'b00}, rand_word());  // Above the window
            halted_transfer(1'b0, {1'b1, r, 2'b11}, '0);
            halted_transfer(1'b0, {1'b0, r, 2'b00}, '0);
        end
        enable = 1'b1;
        for (int i = 0; i < `BANK_DEPTH; i++) pipeline_cycle(1'b0, '0, '0, i[4:0], ~i[4:0]);
        finish_test("APB debug access");

        for (int i = 0; i < 4; i++) begin
            r      = rand_reg();
            enable = 1'b1;
            apb_transfer(1'b1, {1'b0, r, 2'b00}, rand_word(), 2 + i, cycles);
            check_stalled_length(cycles, 2 + i);
            enable = 1'b1;
            apb_transfer(1'b0, {1'b0, r, 2'b00}, '0, 3, cycles);
            check_stalled_length(cycles, 3);
            enable = 1'b1;
            pipeline_cycle(1'b0, '0, '0, r, r);
        end
        finish_test("APB back-pressure while running");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* regfile_debug.f */
+incdir+include
source/regfile_pkg.sv
source/debug_pkg.sv
source/regfile_ifs.sv
source/write_decoder.sv
source/register_slice.sv
source/read_port_mux.sv
source/apb_debug_port.sv
source/register_bank_top.sv
verification/clock_reset_gen.sv
verification/register_bank_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the register bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module register_bank_tb -f regfile_debug.f

output=$(./obj_dir/Vregister_bank_tb)
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
